// ==== Bender.yml ====
package:
  name: rvv_pcpi

sources:
  - logic/rvv_pkg.sv
  - logic/rvv_decode.sv
  - logic/rvv_scalar_unit.sv
  - logic/rvv_elem_unit.sv
  - logic/rvv_vregs.sv
  - logic/rvv_pcpi_ctrl.sv
  - logic/rvv_pcpi_top.sv
  - target: test
    files:
      - tb/tb_rvv_pcpi.sv

// ==== compile.f ====
logic/rvv_pkg.sv
logic/rvv_decode.sv
logic/rvv_scalar_unit.sv
logic/rvv_elem_unit.sv
logic/rvv_vregs.sv
logic/rvv_pcpi_ctrl.sv
logic/rvv_pcpi_top.sv
tb/tb_rvv_pcpi.sv

// ==== logic/rvv_decode.sv ====
`timescale 1ns/100ps

module rvv_decode import rvv_pkg::*; (
	input  rvv_insn_u insn_i,
	output rvv_dec_t  dec_o
);

	logic grp_op; // move or merge

	always_comb begin
		dec_o = '0;
		if (insn_i.op.opcode == OPC_OP_V) begin
			case (insn_i.op.funct3)
				F3_CFG: begin
					dec_o.vsetvli  = !insn_i.cfg.kind[1];
					dec_o.vsetivli = insn_i.cfg.kind == 2'b11;
					// vsetvl needs insn[29:25] clear
					dec_o.vsetvl   = insn_i.cfg.kind == 2'b10 && insn_i.cfg.zimm[9:5] == '0;
				end
				F3_OPIVV, F3_OPIVX, F3_OPIVI: begin
					if (insn_i.op.funct6 == F6_MERGE) begin
						dec_o.merge = !insn_i.op.vm;
						dec_o.move  = insn_i.op.vm && insn_i.op.vs2 == '0;
					end
				end
				F3_OPMVV: begin
					if (insn_i.op.funct6 == F6_WXUNARY && insn_i.op.vm) begin
						dec_o.vmv_x_s = insn_i.op.vs1 == 5'b00000;
						dec_o.cpop    = insn_i.op.vs1 == 5'b10000;
					end
				end
				default: ;
			endcase
		end

		grp_op = dec_o.move | dec_o.merge;
		dec_o.src_vv = grp_op && insn_i.op.funct3 == F3_OPIVV;
		dec_o.src_vx = grp_op && insn_i.op.funct3 == F3_OPIVX;
		dec_o.src_vi = grp_op && insn_i.op.funct3 == F3_OPIVI;

		dec_o.is_rvv = |{dec_o.vsetvli, dec_o.vsetivli, dec_o.vsetvl,
			grp_op, dec_o.vmv_x_s, dec_o.cpop};
	end

endmodule

// ==== logic/rvv_elem_unit.sv ====
`timescale 1ns/100ps

module rvv_elem_unit import rvv_pkg::*; (
	input  logic             clk,
	input  logic             resetn,
	input  logic             start_i,
	input  rvv_dec_t         dec_i,
	input  rvv_insn_u        insn_i,
	input  logic [31:0]      rs1_i,
	input  vcfg_t            cfg_i,
	input  logic [VLEN-1:0]  rd1_data_i,
	input  logic [VLEN-1:0]  rd2_data_i,
	input  logic [VLEN-1:0]  rd3_data_i,
	input  logic [VLEN-1:0]  v0_i,
	output logic [4:0]       rd1_addr_o,
	output logic [4:0]       rd2_addr_o,
	output logic [4:0]       rd3_addr_o,
	output logic             we_o,
	output logic [4:0]       waddr_o,
	output logic [VLEN-1:0]  wdata_o,
	output unit_res_t        res_o
);

	logic                 active;
	logic [GRP_IDX_W-1:0] idx;      // register within the group
	logic [GRP_IDX_W-1:0] last_idx;
	logic [7:0]           remain;   // elements left from this register on
	logic [1:0]           sew_l;
	logic [7:0]           epr;      // elements per register
	logic [6:0]           v0_base;
	logic [63:0]          scal;     // scalar operand at e64, narrowed per byte

	assign sew_l    = cfg_i.vtype.vsew[1:0];
	assign epr      = 8'(VLENB) >> sew_l;
	assign last_idx = cfg_i.vtype.vlmul[2] ? '0
		: (GRP_IDX_W'(1) << cfg_i.vtype.vlmul[1:0]) - 1'b1;
	assign v0_base  = 7'(8'(idx) * epr);

	assign rd1_addr_o = insn_i.op.vs1 + 5'(idx);
	assign rd2_addr_o = insn_i.op.vs2 + 5'(idx);
	assign rd3_addr_o = insn_i.op.vd + 5'(idx); // old vd for the tail
	assign waddr_o    = insn_i.op.vd + 5'(idx);
	assign we_o       = active;

	always_comb begin
		scal = '0;
		if (dec_i.src_vi)
			scal = {{59{insn_i.op.vs1[4]}}, insn_i.op.vs1};
		else if (dec_i.src_vx)
			scal = {{32{rs1_i[31]}}, rs1_i};
	end

	// byte-wise so every SEW shares one datapath
	always_comb begin
		logic [3:0] elem;
		logic [7:0] src_b;
		logic [7:0] new_b;
		for (int b = 0; b < VLENB; b++) begin
			elem  = 4'(b >> sew_l);
			src_b = dec_i.src_vv ? rd1_data_i[b*8 +: 8]
				: scal[8*(b & ((1 << sew_l) - 1)) +: 8];
			// v0 bit picks vs1/scalar, else vs2
			new_b = (dec_i.merge && !v0_i[v0_base + 7'(elem)]) ? rd2_data_i[b*8 +: 8] : src_b;
			wdata_o[b*8 +: 8] = (8'(elem) < remain) ? new_b : rd3_data_i[b*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			idx    <= '0;
			remain <= '0;
			res_o  <= '0;
		end else begin
			res_o <= '0;
			if (start_i && (dec_i.move || dec_i.merge)) begin
				if (cfg_i.vl == '0 || cfg_i.vtype.vill) begin
					res_o.done <= 1'b1; // nothing to write
				end else begin
					active <= 1'b1;
					idx    <= '0;
					remain <= cfg_i.vl;
				end
			end else if (active) begin
				if (idx == last_idx) begin
					active     <= 1'b0;
					idx        <= '0;
					res_o.done <= 1'b1;
				end else begin
					idx    <= idx + 1'b1;
					remain <= (remain > epr) ? remain - epr : 8'd0;
				end
			end
		end
	end

	a_idx_in_group: assert property (@(posedge clk) disable iff (!resetn)
		active |-> (idx < GRP_IDX_W'(MAX_LMUL)) && (idx <= last_idx));

endmodule

// ==== logic/rvv_pcpi_ctrl.sv ====
`timescale 1ns/100ps

module rvv_pcpi_ctrl import rvv_pkg::*; (
	input  logic         clk,
	input  logic         resetn,
	input  logic         pcpi_valid_i,
	input  rvv_dec_t     dec_i,
	input  unit_res_t    scal_res_i,
	input  unit_res_t    elem_res_i,
	output logic         start_o,
	output logic         pcpi_wr_o,
	output logic [31:0]  pcpi_rd_o,
	output logic         pcpi_wait_o,
	output logic         pcpi_ready_o
);

	logic        busy;
	logic        accept;
	logic        any_done;
	logic        res_wr;
	logic [31:0] res_rd;

	// valid still high during ready belongs to the finished insn
	assign accept   = pcpi_valid_i && dec_i.is_rvv && !busy && !pcpi_ready_o;
	assign any_done = scal_res_i.done | elem_res_i.done;

	// at most one unit reports per instruction
	assign res_wr = (scal_res_i.done & scal_res_i.wr) | (elem_res_i.done & elem_res_i.wr);
	assign res_rd = (scal_res_i.done ? scal_res_i.rd : 32'd0)
		| (elem_res_i.done ? elem_res_i.rd : 32'd0);

	always_ff @(posedge clk) begin
		pcpi_rd_o <= any_done ? res_rd : 32'd0;
		if (!resetn) begin
			busy         <= 1'b0;
			start_o      <= 1'b0;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o    <= 1'b0;
			pcpi_wait_o  <= 1'b0;
		end else begin
			start_o      <= accept; // one cycle only, busy blocks a repeat
			pcpi_ready_o <= busy && any_done;
			pcpi_wr_o    <= busy && res_wr;
			pcpi_wait_o  <= (start_o || pcpi_wait_o) && !any_done;
			if (accept)
				busy <= 1'b1;
			else if (any_done)
				busy <= 1'b0;
		end
	end

	a_one_done: assert property (@(posedge clk) disable iff (!resetn)
		!(scal_res_i.done && elem_res_i.done));

endmodule

// ==== logic/rvv_pcpi_top.sv ====
`timescale 1ns/100ps

module rvv_pcpi_top import rvv_pkg::*; (
	input  logic         clk,
	input  logic         resetn,
	input  logic         pcpi_valid_i,
	input  logic [31:0]  pcpi_insn_i,
	input  logic [31:0]  pcpi_rs1_i,
	input  logic [31:0]  pcpi_rs2_i,
	output logic         pcpi_wr_o,
	output logic [31:0]  pcpi_rd_o,
	output logic         pcpi_wait_o,
	output logic         pcpi_ready_o,
	output logic         pcpi_is_rvv_o
);

	rvv_dec_t        dec;
	logic            start;
	unit_res_t       scal_res;
	unit_res_t       elem_res;
	vcfg_t           cfg;
	logic [4:0]      vs2_addr;
	logic [4:0]      rd1_addr, rd2_addr, rd3_addr;
	logic            we;
	logic [4:0]      waddr;
	logic [VLEN-1:0] wdata;
	logic [VLEN-1:0] vs2_data, rd1_data, rd2_data, rd3_data;
	logic [VLEN-1:0] v0;

	assign pcpi_is_rvv_o = dec.is_rvv;

	rvv_decode u_decode (.insn_i(pcpi_insn_i), .dec_o(dec));

	rvv_pcpi_ctrl u_ctrl (
		.clk(clk), .resetn(resetn), .pcpi_valid_i(pcpi_valid_i), .dec_i(dec),
		.scal_res_i(scal_res), .elem_res_i(elem_res), .start_o(start),
		.pcpi_wr_o(pcpi_wr_o), .pcpi_rd_o(pcpi_rd_o),
		.pcpi_wait_o(pcpi_wait_o), .pcpi_ready_o(pcpi_ready_o)
	);

	rvv_scalar_unit u_scalar (
		.clk(clk), .resetn(resetn), .start_i(start), .dec_i(dec), .insn_i(pcpi_insn_i),
		.rs1_i(pcpi_rs1_i), .rs2_i(pcpi_rs2_i), .vs2_data_i(vs2_data),
		.cfg_o(cfg), .vs2_addr_o(vs2_addr), .res_o(scal_res)
	);

	rvv_elem_unit u_elem (
		.clk(clk), .resetn(resetn), .start_i(start), .dec_i(dec), .insn_i(pcpi_insn_i),
		.rs1_i(pcpi_rs1_i), .cfg_i(cfg),
		.rd1_data_i(rd1_data), .rd2_data_i(rd2_data), .rd3_data_i(rd3_data), .v0_i(v0),
		.rd1_addr_o(rd1_addr), .rd2_addr_o(rd2_addr), .rd3_addr_o(rd3_addr),
		.we_o(we), .waddr_o(waddr), .wdata_o(wdata), .res_o(elem_res)
	);

	rvv_vregs u_vregs (
		.clk(clk), .we_i(we), .waddr_i(waddr), .wdata_i(wdata),
		.raddr1_i(rd1_addr), .raddr2_i(rd2_addr), .raddr3_i(rd3_addr), .raddr4_i(vs2_addr),
		.rdata1_o(rd1_data), .rdata2_o(rd2_data), .rdata3_o(rd3_data), .rdata4_o(vs2_data),
		.v0_o(v0)
	);

endmodule

// ==== logic/rvv_pkg.sv ====
package rvv_pkg;

	localparam int VLEN      = 128;
	localparam int VLENB     = VLEN / 8; // bytes per vector register
	localparam int NUM_VREGS = 32;
	localparam int MAX_LMUL  = 8;
	localparam int GRP_IDX_W = $clog2(MAX_LMUL) + 1; // one spare bit to catch overrun

	localparam logic [6:0] OPC_OP_V = 7'b1010111;

	// funct3 of the OP-V major opcode
	localparam logic [2:0] F3_OPIVV = 3'b000;
	localparam logic [2:0] F3_OPMVV = 3'b010;
	localparam logic [2:0] F3_OPIVI = 3'b011;
	localparam logic [2:0] F3_OPIVX = 3'b100;
	localparam logic [2:0] F3_CFG   = 3'b111;

	localparam logic [5:0] F6_MERGE   = 6'b010111; // vmerge, vmv.v.*
	localparam logic [5:0] F6_WXUNARY = 6'b010000; // vmv.x.s, vcpop.m

	typedef struct packed {
		logic       vill;
		logic       vma;
		logic       vta;
		logic [2:0] vsew;
		logic [2:0] vlmul;
	} vtype_t;

	localparam vtype_t VTYPE_ILL = '{vill: 1'b1, default: '0};

	typedef struct packed {
		vtype_t     vtype;
		logic [7:0] vl; // up to 128 elements at e8, m8
	} vcfg_t;

	// arithmetic format
	typedef struct packed {
		logic [5:0] funct6;
		logic       vm;
		logic [4:0] vs2;
		logic [4:0] vs1;
		logic [2:0] funct3;
		logic [4:0] vd;
		logic [6:0] opcode;
	} rvv_op_fmt_t;

	// vsetvli / vsetivli / vsetvl format
	typedef struct packed {
		logic [1:0] kind;   // insn[31:30]
		logic [9:0] zimm;   // vtype immediate, rs2 in zimm[4:0] for vsetvl
		logic [4:0] rs1;    // uimm for vsetivli
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rvv_cfg_fmt_t;

	typedef union packed {
		rvv_op_fmt_t  op;
		rvv_cfg_fmt_t cfg;
	} rvv_insn_u;

	typedef struct packed {
		logic is_rvv;
		logic vsetvli;
		logic vsetivli;
		logic vsetvl;
		logic move;
		logic merge;
		logic vmv_x_s;
		logic cpop;
		logic src_vv;
		logic src_vx;
		logic src_vi;
	} rvv_dec_t;

	typedef struct packed {
		logic        done;
		logic        wr;
		logic [31:0] rd;
	} unit_res_t;

endpackage

// ==== logic/rvv_scalar_unit.sv ====
`timescale 1ns/100ps

module rvv_scalar_unit import rvv_pkg::*; (
	input  logic             clk,
	input  logic             resetn,
	input  logic             start_i,
	input  rvv_dec_t         dec_i,
	input  rvv_insn_u        insn_i,
	input  logic [31:0]      rs1_i,
	input  logic [31:0]      rs2_i,
	input  logic [VLEN-1:0]  vs2_data_i,
	output vcfg_t            cfg_o,
	output logic [4:0]       vs2_addr_o,
	output unit_res_t        res_o
);

	vcfg_t       cfg_q;
	vtype_t      new_vtype;
	logic [7:0]  vlbase;
	logic [7:0]  vlmax;
	logic [7:0]  new_vl;
	logic [31:0] avl;
	logic        cfg_bad;
	logic        is_cfg;
	logic [31:0] elem0;
	logic [7:0]  pop;

	assign cfg_o      = cfg_q;
	assign vs2_addr_o = insn_i.op.vs2; // vs2 base for vmv.x.s and vcpop.m
	assign is_cfg     = dec_i.vsetvli | dec_i.vsetivli | dec_i.vsetvl;

	// new vtype and vl
	always_comb begin
		new_vtype = '0;
		if (dec_i.vsetvl)
			{new_vtype.vma, new_vtype.vta, new_vtype.vsew, new_vtype.vlmul} = rs2_i[7:0];
		else
			{new_vtype.vma, new_vtype.vta, new_vtype.vsew, new_vtype.vlmul} = insn_i.cfg.zimm[7:0];

		vlbase = 8'(VLENB) >> new_vtype.vsew[1:0]; // elements per register
		case (new_vtype.vlmul)
			3'b000, 3'b001, 3'b010, 3'b011: vlmax = vlbase << new_vtype.vlmul[1:0];
			3'b101: vlmax = vlbase >> 3;
			3'b110: vlmax = vlbase >> 2;
			3'b111: vlmax = vlbase >> 1;
			default: vlmax = '0; // reserved
		endcase
		cfg_bad = new_vtype.vsew[2] || vlmax == '0;

		if (dec_i.vsetivli)
			avl = 32'(insn_i.cfg.rs1);
		else if (insn_i.cfg.rs1 != '0)
			avl = rs1_i;
		else if (insn_i.cfg.rd != '0)
			avl = '1; // request vlmax
		else
			avl = 32'(cfg_q.vl);
		new_vl = (avl < 32'(vlmax)) ? avl[7:0] : vlmax;
	end

	always_comb begin
		case (cfg_q.vtype.vsew)
			3'b000: elem0 = {{24{vs2_data_i[7]}}, vs2_data_i[7:0]};
			3'b001: elem0 = {{16{vs2_data_i[15]}}, vs2_data_i[15:0]};
			default: elem0 = vs2_data_i[31:0]; // e64 returns the low word
		endcase

		pop = '0;
		for (int k = 0; k < VLEN; k++) begin
			if (k < int'(cfg_q.vl) && vs2_data_i[k])
				pop = pop + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg_q.vtype <= VTYPE_ILL;
			cfg_q.vl    <= '0;
			res_o       <= '0;
		end else begin
			res_o <= '0;
			if (start_i) begin
				if (is_cfg) begin
					cfg_q.vtype <= cfg_bad ? VTYPE_ILL : new_vtype;
					cfg_q.vl    <= cfg_bad ? 8'd0 : new_vl;
					res_o       <= '{done: 1'b1, wr: 1'b1, rd: cfg_bad ? 32'd0 : 32'(new_vl)};
				end else if (dec_i.vmv_x_s) begin
					res_o <= '{done: 1'b1, wr: 1'b1, rd: elem0};
				end else if (dec_i.cpop) begin
					res_o <= '{done: 1'b1, wr: 1'b1, rd: 32'(pop)};
				end
			end
		end
	end

endmodule

// ==== logic/rvv_vregs.sv ====
`timescale 1ns/100ps

module rvv_vregs import rvv_pkg::*; (
	input  logic             clk,
	input  logic             we_i,
	input  logic [4:0]       waddr_i,
	input  logic [VLEN-1:0]  wdata_i,
	input  logic [4:0]       raddr1_i,
	input  logic [4:0]       raddr2_i,
	input  logic [4:0]       raddr3_i,
	input  logic [4:0]       raddr4_i,
	output logic [VLEN-1:0]  rdata1_o,
	output logic [VLEN-1:0]  rdata2_o,
	output logic [VLEN-1:0]  rdata3_o,
	output logic [VLEN-1:0]  rdata4_o,
	output logic [VLEN-1:0]  v0_o
);

	logic [VLEN-1:0] regs [NUM_VREGS];
	logic [VLEN-1:0] v0_q; // mask copy, saves a fifth read mux

	// power-up contents
	initial begin
		for (int i = 0; i < NUM_VREGS; i++)
			regs[i] = '0;
		v0_q = '0;
	end

	always @(posedge clk) begin
		if (we_i)
			regs[waddr_i] <= wdata_i;
		if (we_i && waddr_i == 5'd0)
			v0_q <= wdata_i;
	end

	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];
	assign rdata3_o = regs[raddr3_i];
	assign rdata4_o = regs[raddr4_i];
	assign v0_o     = v0_q;

	a_waddr_known: assert property (@(posedge clk) we_i |-> !$isunknown(waddr_i));

endmodule

// ==== tb/tb_rvv_pcpi.sv ====
`timescale 1ns/100ps

module tb_rvv_pcpi import rvv_pkg::*; ();

	localparam int N_INSN = 48; // upper bound of instructions issued

	logic        clk;
	logic        resetn;
	logic        pcpi_valid;
	logic [31:0] pcpi_insn;
	logic [31:0] pcpi_rs1;
	logic [31:0] pcpi_rs2;
	logic        pcpi_wr;
	logic [31:0] pcpi_rd;
	logic        pcpi_wait;
	logic        pcpi_ready;
	logic        pcpi_is_rvv;

	int          seed = 32'h8d797644;
	int          errors = 0;
	int          err_mark = 0;
	int          tests = 0;
	int          failed = 0;
	logic        chk_scalar; // current insn returns a value
	logic        bad_word;   // current insn is not a vector insn
	logic [31:0] exp_rd;

	// reference state
	logic [VLEN-1:0] m_regs [NUM_VREGS];
	int              m_vl;
	logic [2:0]      m_sew;
	logic            m_ill;

	rvv_pcpi_top uut (
		.clk(clk), .resetn(resetn), .pcpi_valid_i(pcpi_valid), .pcpi_insn_i(pcpi_insn),
		.pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2), .pcpi_wr_o(pcpi_wr),
		.pcpi_rd_o(pcpi_rd), .pcpi_wait_o(pcpi_wait), .pcpi_ready_o(pcpi_ready),
		.pcpi_is_rvv_o(pcpi_is_rvv)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic log_error(string msg);
		errors++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	a_reset_idle: assert property (@(posedge clk)
		$rose(resetn) |-> !pcpi_ready && !pcpi_wr && !pcpi_wait)
		else log_error("outputs active after reset");
	a_not_rvv: assert property (@(posedge clk)
		pcpi_valid && bad_word |-> !pcpi_is_rvv && !pcpi_ready)
		else log_error("non-vector word was claimed");
	a_is_rvv: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_valid && !bad_word |-> pcpi_is_rvv)
		else log_error("vector word not claimed");
	a_scalar_timing: assert property (@(posedge clk) disable iff (!resetn)
		$rose(pcpi_valid) && chk_scalar
			|-> ##1 !pcpi_ready ##1 !pcpi_ready ##1 (pcpi_ready && pcpi_wr))
		else log_error("scalar response not three cycles after valid");
	a_scalar_value: assert property (@(posedge clk) pcpi_ready && chk_scalar |-> pcpi_rd == exp_rd)
		else log_error($sformatf("rd %h, expected %h", $sampled(pcpi_rd), $sampled(exp_rd)));
	a_group_no_wr: assert property (@(posedge clk) pcpi_ready && !chk_scalar |-> !pcpi_wr)
		else log_error("group op wrote rd");
	a_wait_held: assert property (@(posedge clk) disable iff (!resetn)
		$rose(pcpi_wait) |-> pcpi_wait until pcpi_ready)
		else log_error("wait dropped before ready");
	a_wait_before_ready: assert property (@(posedge clk) disable iff (!resetn)
		$rose(pcpi_ready) |-> $past(pcpi_wait))
		else log_error("wait was low in the cycle before ready");

	initial begin
		#(N_INSN * 12 * 10 + 2000);
		$display("timeout: the DUT stopped answering");
		$display("Testbench failed");
		$finish;
	end

	function automatic int vlmax_of(logic [2:0] vsew, logic [2:0] vlmul);
		int per_reg;
		if (vsew > 3'd3 || vlmul == 3'b100)
			return 0;
		per_reg = VLEN / (8 << vsew);
		if (vlmul[2])
			return per_reg / (1 << (8 - vlmul)); // fractional lmul
		return per_reg * (1 << vlmul);
	endfunction

	function automatic logic [63:0] get_elem(int vr, int i);
		int         w;
		int         epr;
		logic [63:0] v;
		w = 8 << m_sew;
		epr = VLEN / w;
		v = '0;
		for (int j = 0; j < w; j++)
			v[j] = m_regs[vr + i / epr][(i % epr) * w + j];
		return v;
	endfunction

	task automatic put_elem(int vr, int i, logic [63:0] v);
		int w;
		int epr;
		w = 8 << m_sew;
		epr = VLEN / w;
		for (int j = 0; j < w; j++)
			m_regs[vr + i / epr][(i % epr) * w + j] = v[j];
	endtask

	function automatic logic [31:0] enc_op(logic [5:0] f6, logic vm, logic [4:0] vs2,
		logic [4:0] vs1, logic [2:0] f3, logic [4:0] vd);
		return {f6, vm, vs2, vs1, f3, vd, OPC_OP_V};
	endfunction

	// drive one insn and hold valid until ready
	task automatic issue(logic [31:0] insn, logic [31:0] rs1, logic [31:0] rs2,
		logic scalar, logic [31:0] expect_rd);
		@(posedge clk);
		pcpi_insn  <= insn;
		pcpi_rs1   <= rs1;
		pcpi_rs2   <= rs2;
		pcpi_valid <= 1'b1;
		chk_scalar <= scalar;
		exp_rd     <= expect_rd;
		do @(posedge clk); while (!pcpi_ready);
		pcpi_valid <= 1'b0;
		@(posedge clk);
	endtask

	// kind 0 vsetvli, 1 vsetivli, 2 vsetvl
	task automatic set_vtype(int kind, logic [4:0] rd, logic [4:0] rs1_idx,
		logic [31:0] rs1_val, logic [7:0] vt);
		longint unsigned avl;
		int              lmax;
		logic [31:0]     insn;
		lmax = vlmax_of(vt[5:3], vt[2:0]);
		if (kind == 1)
			avl = rs1_idx;
		else if (rs1_idx != 0)
			avl = rs1_val;
		else if (rd != 0)
			avl = 64'hffff_ffff;
		else
			avl = m_vl;
		m_ill = lmax == 0;
		m_sew = vt[5:3];
		m_vl = (avl < lmax) ? int'(avl) : lmax;
		if (kind == 0)
			insn = {1'b0, 3'b000, vt, rs1_idx, F3_CFG, rd, OPC_OP_V};
		else if (kind == 1)
			insn = {2'b11, 2'b00, vt, rs1_idx, F3_CFG, rd, OPC_OP_V};
		else
			insn = {7'b1000000, 5'd7, rs1_idx, F3_CFG, rd, OPC_OP_V};
		issue(insn, rs1_val, {24'd0, vt}, 1'b1, m_vl);
	endtask

	// form 0 vv, 1 vx, 2 vi
	task automatic move_or_merge(logic merge, int form, logic [4:0] vd, logic [4:0] vs2,
		logic [4:0] vs1, logic [31:0] rs1_val);
		logic [2:0]  f3;
		logic [63:0] src;
		f3 = (form == 0) ? F3_OPIVV : (form == 1) ? F3_OPIVX : F3_OPIVI;
		for (int i = 0; i < m_vl && !m_ill; i++) begin
			if (form == 0)
				src = get_elem(vs1, i);
			else if (form == 1)
				src = {{32{rs1_val[31]}}, rs1_val};
			else
				src = {{59{vs1[4]}}, vs1};
			if (merge && !m_regs[0][i])
				src = get_elem(vs2, i);
			put_elem(vd, i, src);
		end
		issue(enc_op(F6_MERGE, !merge, merge ? vs2 : 5'd0, vs1, f3, vd), rs1_val, '0,
			1'b0, '0);
	endtask

	task automatic read_scalar(logic cpop, logic [4:0] vs2);
		logic [63:0] e;
		logic [31:0] r;
		e = get_elem(vs2, 0);
		if (cpop) begin
			r = 0;
			for (int i = 0; i < m_vl; i++)
				r += m_regs[vs2][i];
		end else if (m_sew == 3'd0) begin
			r = 32'($signed(e[7:0]));
		end else if (m_sew == 3'd1) begin
			r = 32'($signed(e[15:0]));
		end else begin
			r = e[31:0];
		end
		issue(enc_op(F6_WXUNARY, 1'b1, vs2, cpop ? 5'b10000 : 5'd0, F3_OPMVV, 5'd10), '0, '0,
			1'b1, r);
	endtask

	task automatic report_test(string name);
		tests++;
		if (errors != err_mark)
			failed++;
		$display("test %s %s", name, (errors != err_mark) ? "FAILED" : "ok");
		err_mark = errors;
	endtask

	initial begin
		for (int i = 0; i < NUM_VREGS; i++)
			m_regs[i] = '0;
		m_vl = 0;
		m_sew = '0;
		m_ill = 1'b1;
		resetn = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn = '0;
		pcpi_rs1 = '0;
		pcpi_rs2 = '0;
		chk_scalar = 1'b0;
		bad_word = 1'b0;
		exp_rd = '0;
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);

		// plain add, must be ignored
		pcpi_insn <= 32'h00c58533;
		bad_word <= 1'b1;
		pcpi_valid <= 1'b1;
		repeat (6) @(posedge clk);
		pcpi_valid <= 1'b0;
		bad_word <= 1'b0;
		@(posedge clk);
		report_test("reset");

		for (int i = 0; i < 6; i++)
			set_vtype(i % 3, 5'd1 + 5'(i), 5'd3 + 5'(i), $random(seed) & 32'h1ff,
				{2'($random(seed)), 3'($random(seed) & 3), 3'($random(seed))});
		set_vtype(0, 5'd1, 5'd0, '0, 8'h0a); // x0 avl gives vlmax
		set_vtype(0, 5'd0, 5'd0, '0, 8'h03); // keeps old vl
		set_vtype(0, 5'd2, 5'd5, 32'd9, 8'h04);
		set_vtype(2, 5'd2, 5'd5, 32'd9, 8'h20);
		report_test("vset");

		set_vtype(0, 5'd1, 5'd5, 32'd4, 8'h10);
		move_or_merge(1'b0, 1, 5'd3, 5'd0, 5'd0, $random(seed));
		read_scalar(1'b0, 5'd3);
		move_or_merge(1'b0, 2, 5'd4, 5'd0, 5'($random(seed)), '0);
		set_vtype(1, 5'd1, 5'd16, '0, 8'h00);
		read_scalar(1'b0, 5'd4);
		report_test("vmv");

		set_vtype(0, 5'd1, 5'd5, 32'd4, 8'h10);
		move_or_merge(1'b0, 1, 5'd0, 5'd0, 5'd0, $random(seed));
		move_or_merge(1'b0, 1, 5'd6, 5'd0, 5'd0, $random(seed));
		move_or_merge(1'b0, 1, 5'd7, 5'd0, 5'd0, $random(seed));
		for (int f = 0; f < 3; f++) begin
			set_vtype(0, 5'd1, 5'd5, 32'd1 + ($random(seed) & 15), 8'h00);
			move_or_merge(1'b1, f, 5'd10 + 5'(f), 5'd6, (f == 0) ? 5'd7 : 5'($random(seed)),
				$random(seed));
			set_vtype(0, 5'd1, 5'd5, 32'd128, 8'h03);
			read_scalar(1'b1, 5'd10 + 5'(f));
		end
		report_test("vmerge");

		set_vtype(0, 5'd1, 5'd5, 32'd32, 8'h01);
		move_or_merge(1'b0, 2, 5'd8, 5'd0, 5'b11111, '0);
		set_vtype(0, 5'd1, 5'd5, 32'd3, 8'h09);
		move_or_merge(1'b0, 1, 5'd8, 5'd0, 5'd0, $random(seed));
		set_vtype(0, 5'd1, 5'd5, 32'd128, 8'h03);
		read_scalar(1'b1, 5'd8);
		read_scalar(1'b1, 5'd9);
		report_test("tail");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
